// File: Makefile
VERILATOR ?= verilator
TOP       := ceres_tb
FILELIST  := compile.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing --assert

.PHONY: all build lint clean

# Simulator exit status carries pass or fail
all: build
	./$(BUILD_DIR)/V$(TOP)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: bench/ceres_assertions.sv
// Bound checks on the bus handshake, first RAM read latency and GPIO reset state
`timescale 1ns/1ps
`include "ceres_config.svh"

module ceres_assertions
  import ceres_mem_pkg::*;
(
  input logic        clk_i,
  input logic        rst_ni,
  input logic        wb_cyc_i,
  input logic        wb_stb_i,
  input logic        wb_we_i,
  input logic        wb_ack_i,
  input logic        ram_stb_i,
  input logic        ram_ack_i,
  input ram_state_e  ram_state_i,
  input logic [31:0] gpio_oe_i
);

  localparam int LATENCY = `CERES_RAM_LATENCY;

  logic read_start;
  logic first_read_ack;

  // Read strobe seen by an idle RAM controller
  assign read_start     = ram_stb_i && !wb_we_i && (ram_state_i == RAM_IDLE);
  // Ack that ends the latency wait
  assign first_read_ack = ram_ack_i && !wb_we_i && (ram_state_i == RAM_WAIT);

  // ==================================================
  // Handshake
  // ==================================================
  ack_needs_request: assert property (@(posedge clk_i) disable iff (!rst_ni)
      wb_ack_i |-> (wb_cyc_i && wb_stb_i))
    else $error("ack raised without a live request");

  // Never early
  first_ack_not_early: assert property (@(posedge clk_i) disable iff (!rst_ni)
      first_read_ack |-> $past(read_start, LATENCY))
    else $error("first RAM read ack not at the configured latency");

  // Never late while the master holds the request
  first_ack_not_late: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $past(read_start, LATENCY) |-> ram_ack_i)
    else $error("first RAM read ack missing at the configured latency");

  // ==================================================
  // Reset state
  // ==================================================
  oe_clear_after_reset: assert property (@(posedge clk_i)
      $rose(rst_ni) |-> (gpio_oe_i == '0))
    else $error("gpio_oe_o not cleared by reset");

endmodule

// File: bench/ceres_tb.sv
// Testbench top: test file reader, Wishbone master, value checks, watchdog and result
`timescale 1ns/1ps
`include "ceres_config.svh"

module ceres_tb
  import ceres_bus_pkg::*;
();

  localparam int LATENCY      = `CERES_RAM_LATENCY;
  localparam int RESET_CYCLES = 5;
  localparam int FIELDS       = 6;
  localparam int MAX_TESTS    = 64;
  // Op codes of the test file
  localparam logic [31:0] OP_WRITE   = 32'h0;
  localparam logic [31:0] OP_BURST   = 32'h2;
  localparam logic [31:0] OP_GPIO_IN = 32'h3;
  localparam logic [31:0] OP_END     = 32'hff;

  logic        clk;
  logic        rst_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [31:0] wb_adr;
  logic [31:0] wb_dat_w;
  logic [3:0]  wb_sel;
  wb_cti_e     wb_cti;
  logic [31:0] gpio_in;
  logic        wb_ack;
  logic [31:0] wb_dat_r;
  logic [31:0] gpio_out;
  logic [31:0] gpio_oe;
  logic [3:0]  status_led;

  // Six words per test line
  logic [31:0] test_mem [MAX_TESTS*FIELDS];
  int          test_count;
  int          check_count;
  logic        tests_loaded;

  tb_clock_gen #(.RESET_CYCLES(RESET_CYCLES)) tb_clock_gen_i (
    .clk_o (clk),
    .rst_no(rst_n)
  );

  ceres_mem_top ceres_mem_top_i (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .wb_cyc_i    (wb_cyc),
    .wb_stb_i    (wb_stb),
    .wb_we_i     (wb_we),
    .wb_adr_i    (wb_adr),
    .wb_dat_i    (wb_dat_w),
    .wb_sel_i    (wb_sel),
    .wb_cti_i    (wb_cti),
    .gpio_i      (gpio_in),
    .wb_ack_o    (wb_ack),
    .wb_dat_o    (wb_dat_r),
    .gpio_o      (gpio_out),
    .gpio_oe_o   (gpio_oe),
    .status_led_o(status_led)
  );

  bind ceres_mem_top ceres_assertions ceres_assertions_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .wb_cyc_i   (wb_cyc_i),
    .wb_stb_i   (wb_stb_i),
    .wb_we_i    (wb_we_i),
    .wb_ack_i   (wb_ack_o),
    .ram_stb_i  (ram_stb),
    .ram_ack_i  (ram_ack),
    .ram_state_i(line_ram_slave_i.state_q),
    .gpio_oe_i  (gpio_oe_o)
  );

  task automatic stop_on_failure();
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped on the first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
      $display("ERR t=%0t %s actual=%h expected=%h", $time, name, actual, expected);
      stop_on_failure();
    end
  endtask

  // Address map from the top nibble
  function automatic slave_sel_e region_of(input logic [31:0] adr);
    if (adr[31:28] == `CERES_RAM_REGION) begin
      return SEL_RAM;
    end
    if (adr[31:28] == `CERES_GPIO_REGION) begin
      return SEL_GPIO;
    end
    return SEL_NONE;
  endfunction

  // ==================================================
  // Bus master
  // ==================================================
  // Called on a falling edge, returns on the falling edge after the ack
  task automatic bus_access(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel, input wb_cti_e cti,
                            output logic [31:0] rdata, output int waits);
    logic acked;
    acked    = 1'b0;
    waits    = 0;
    rdata    = '0;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = dat;
    wb_sel   = sel;
    wb_cti   = cti;
    while (!acked) begin
      // Mid low phase, inputs and outputs settled
      #1;
      if (wb_ack) begin
        acked = 1'b1;
        rdata = wb_dat_r;
      end else if (waits >= LATENCY + 2) begin
        $display("No ack for address %h within %0d cycles", adr, LATENCY + 2);
        stop_on_failure();
      end else begin
        waits++;
      end
      @(negedge clk);
    end
  endtask

  initial begin : main
    logic [31:0] op;
    logic [31:0] adr;
    logic [31:0] dat;
    logic [31:0] exp_data;
    logic [3:0]  sel;
    logic [3:0]  exp_led;
    wb_cti_e     cti;
    slave_sel_e  region;
    logic [31:0] rdata;
    int          waits;
    int          exp_waits;
    int          base;
    logic        in_burst;
    logic        burst_more;
    wb_cyc       = 1'b0;
    wb_stb       = 1'b0;
    wb_we        = 1'b0;
    wb_adr       = '0;
    wb_dat_w     = '0;
    wb_sel       = '0;
    wb_cti       = CTI_CLASSIC;
    gpio_in      = '0;
    check_count  = 0;
    test_count   = 0;
    tests_loaded = 1'b0;
    $readmemh("bench/ceres_tests.txt", test_mem);
    while (test_count < MAX_TESTS && test_mem[test_count*FIELDS] != OP_END) begin
      test_count++;
    end
    if (test_count == MAX_TESTS) begin
      $display("Test file has no end marker");
      stop_on_failure();
    end
    tests_loaded = 1'b1;

    // Reset state
    @(posedge rst_n);
    @(negedge clk);
    #1;
    check_value("wb_ack_o", {31'b0, wb_ack}, 32'h0);
    check_value("status_led_o", {28'b0, status_led}, 32'h0);
    check_value("gpio_o", gpio_out, 32'h0);
    check_value("gpio_oe_o", gpio_oe, 32'h0);
    @(negedge clk);

    // From here on only checks driven by the test file are counted
    check_count = 0;
    in_burst = 1'b0;
    for (int t = 0; t < test_count; t++) begin
      base     = t * FIELDS;
      op       = test_mem[base];
      adr      = test_mem[base + 1];
      dat      = test_mem[base + 2];
      sel      = test_mem[base + 3][3:0];
      cti      = wb_cti_e'(test_mem[base + 4][2:0]);
      exp_data = test_mem[base + 5];
      region   = region_of(adr);
      if (op == OP_GPIO_IN) begin
        gpio_in = dat;
        @(negedge clk);
      end else begin
        // Only the first RAM read of a request pays the latency
        exp_waits = (region == SEL_RAM && op != OP_WRITE && !in_burst) ? LATENCY : 0;
        bus_access(op == OP_WRITE, adr, dat, sel, cti, rdata, waits);
        check_value("wb_ack_o latency", 32'(waits), 32'(exp_waits));
        if (op != OP_WRITE) begin
          check_value("wb_dat_o", rdata, exp_data);
        end
        burst_more = (op == OP_BURST) && (cti == CTI_INCR);
        in_burst   = burst_more;
        if (!burst_more) begin
          wb_cyc = 1'b0;
          wb_stb = 1'b0;
          wb_we  = 1'b0;
          #1;
          exp_led = {1'b0, op == OP_BURST, region};
          check_value("status_led_o", {28'b0, status_led}, {28'b0, exp_led});
          if (op == OP_WRITE && region == SEL_GPIO && adr[7:0] == 8'h00) begin
            check_value("gpio_o", gpio_out, exp_data);
          end
          if (op == OP_WRITE && region == SEL_GPIO && adr[7:0] == 8'h04) begin
            check_value("gpio_oe_o", gpio_oe, exp_data);
          end
          @(negedge clk);
        end
      end
    end

    if (check_count > 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      $display("No checks were run");
      $display("*** TEST FAILED ***");
      $fatal(1, "empty test run");
    end
  end

  // Budget from the number of test lines
  initial begin : watchdog
    wait (tests_loaded);
    repeat (test_count * (LATENCY + 4) + RESET_CYCLES + 2) @(posedge clk);
    $display("Watchdog expired before the tests finished");
    stop_on_failure();
  end

endmodule

// File: bench/ceres_tests.txt
// Columns: op addr data sel cti expected, all hex; expected is read data or GPIO register value
// Ops: 0 write, 1 read, 2 burst beat, 3 drive gpio_i with data, ff end; cti 0 classic 2 incr 7 end
0 80000000 11111111 f 0 00000000
0 80000004 22222222 f 0 00000000
0 80000008 33333333 f 0 00000000
0 8000000c 44444444 f 0 00000000
0 80000040 a5a5a5a5 f 0 00000000
0 800003f0 0badf00d f 0 00000000
1 80000000 00000000 f 0 11111111
1 8000000c 00000000 f 0 44444444
1 80000040 00000000 f 0 a5a5a5a5
1 800003f0 00000000 f 0 0badf00d
0 80000004 0000bb00 2 0 00000000
0 80000004 cc000000 8 0 00000000
1 80000004 00000000 f 0 cc22bb22
2 80000000 00000000 f 2 11111111
2 80000004 00000000 f 2 cc22bb22
2 80000008 00000000 f 2 33333333
2 8000000c 00000000 f 7 44444444
0 20000000 deadbeef f 0 deadbeef
0 20000004 0000ffff 3 0 0000ffff
0 20000000 00005500 2 0 dead55ef
1 20000000 00000000 f 0 dead55ef
1 20000004 00000000 f 0 0000ffff
3 00000000 13579bdf 0 0 00000000
0 20000008 ffffffff f 0 00000000
1 20000008 00000000 f 0 13579bdf
1 2000000c 00000000 f 0 00000000
1 30000000 00000000 f 0 00000000
0 30000000 12345678 f 0 00000000
1 80000000 00000000 f 0 11111111
ff 00000000 00000000 0 0 00000000

// File: bench/tb_clock_gen.sv
// Testbench clock source and power-on reset generator
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int HALF_PERIOD_NS = 2,
  parameter int RESET_CYCLES   = 5
) (
  output logic clk_o,
  output logic rst_no
);

  // 4 ns period
  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD_NS clk_o = ~clk_o;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// File: compile.f
+incdir+design
design/ceres_bus_pkg.sv
design/ceres_mem_pkg.sv
design/line_ram_slave.sv
design/gpio_reg_slave.sv
design/wb_slave_router.sv
design/ceres_mem_top.sv
bench/tb_clock_gen.sv
bench/ceres_assertions.sv
bench/ceres_tb.sv

// File: design/ceres_bus_pkg.sv
// Wishbone-side types: cycle type identifier and slave select code
package ceres_bus_pkg;

  // Wishbone B4 cycle type identifier
  // Only the codes this bus uses
  typedef enum logic [2:0] {
    CTI_CLASSIC = 3'b000,
    // Incrementing burst, more beats follow
    CTI_INCR    = 3'b010,
    // Last beat of a burst
    CTI_EOB     = 3'b111
  } wb_cti_e;

  // Slave picked by the address decoder
  // Code also shown on the status LEDs
  typedef enum logic [1:0] {
    SEL_NONE = 2'd0,
    SEL_RAM  = 2'd1,
    SEL_GPIO = 2'd2
  } slave_sel_e;

endpackage

// File: design/ceres_config.svh
// RAM depth, read latency, cache-line width and address-region defines
`ifndef CERES_CONFIG_SVH
`define CERES_CONFIG_SVH

// ==================================================
// RAM geometry
// ==================================================
// Depth in 32-bit words
`define CERES_RAM_WORDS 256
// Cycles from first read strobe to ack, at least 2
`define CERES_RAM_LATENCY 4
// One line holds four words
`define CERES_LINE_W 128

// ==================================================
// Address map, bits 31:28
// ==================================================
// Main RAM at 0x8000_0000
`define CERES_RAM_REGION 4'h8
// GPIO block at 0x2000_0000
`define CERES_GPIO_REGION 4'h2

`endif

// File: design/ceres_mem_pkg.sv
// RAM-side types: read controller state and word position in a line
package ceres_mem_pkg;

  // Read controller states
  typedef enum logic [1:0] {
    // No read outstanding
    RAM_IDLE  = 2'd0,
    // First beat waiting on the latency pipeline
    RAM_WAIT  = 2'd1,
    // Later beats served from the line buffer
    RAM_BURST = 2'd2
  } ram_state_e;

  // Word index inside a 128-bit line, address bits 3:2
  typedef logic [1:0] word_off_t;

endpackage

// File: design/ceres_mem_top.sv
// Memory-side top level: router, cache-line RAM slave and GPIO slave
`timescale 1ns/1ps

module ceres_mem_top
  import ceres_bus_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  logic [31:0] wb_adr_i,
  input  logic [31:0] wb_dat_i,
  input  logic [3:0]  wb_sel_i,
  input  wb_cti_e     wb_cti_i,
  input  logic [31:0] gpio_i,
  output logic        wb_ack_o,
  output logic [31:0] wb_dat_o,
  output logic [31:0] gpio_o,
  output logic [31:0] gpio_oe_o,
  output logic [3:0]  status_led_o
);

  // Gated strobes and slave responses
  logic        ram_stb;
  logic        gpio_stb;
  logic        ram_ack;
  logic [31:0] ram_rdata;
  logic        gpio_ack;
  logic [31:0] gpio_rdata;
  logic        ram_burst_active;

  // ==================================================
  // Decode and response mux
  // ==================================================
  wb_slave_router wb_slave_router_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cyc_i         (wb_cyc_i),
    .stb_i         (wb_stb_i),
    .adr_i         (wb_adr_i),
    .ram_ack_i     (ram_ack),
    .ram_rdata_i   (ram_rdata),
    .gpio_ack_i    (gpio_ack),
    .gpio_rdata_i  (gpio_rdata),
    .burst_active_i(ram_burst_active),
    .ram_stb_o     (ram_stb),
    .gpio_stb_o    (gpio_stb),
    .ack_o         (wb_ack_o),
    .rdata_o       (wb_dat_o),
    .status_led_o  (status_led_o)
  );

  // ==================================================
  // Slaves
  // ==================================================
  // Shared request lines go straight to both
  line_ram_slave line_ram_slave_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .stb_i         (ram_stb),
    .we_i          (wb_we_i),
    .adr_i         (wb_adr_i),
    .wdata_i       (wb_dat_i),
    .sel_i         (wb_sel_i),
    .cti_i         (wb_cti_i),
    .ack_o         (ram_ack),
    .rdata_o       (ram_rdata),
    .burst_active_o(ram_burst_active)
  );

  gpio_reg_slave gpio_reg_slave_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .stb_i    (gpio_stb),
    .we_i     (wb_we_i),
    .adr_i    (wb_adr_i),
    .wdata_i  (wb_dat_i),
    .sel_i    (wb_sel_i),
    .gpio_i   (gpio_i),
    .ack_o    (gpio_ack),
    .rdata_o  (gpio_rdata),
    .gpio_o   (gpio_o),
    .gpio_oe_o(gpio_oe_o)
  );

endmodule

// File: design/gpio_reg_slave.sv
// GPIO slave: output and output-enable registers with input readback
`timescale 1ns/1ps

module gpio_reg_slave (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        stb_i,
  input  logic        we_i,
  input  logic [31:0] adr_i,
  input  logic [31:0] wdata_i,
  input  logic [3:0]  sel_i,
  input  logic [31:0] gpio_i,
  output logic        ack_o,
  output logic [31:0] rdata_o,
  output logic [31:0] gpio_o,
  output logic [31:0] gpio_oe_o
);

  // Word indices of the register map
  localparam logic [5:0] REG_OUT = 6'd0;
  localparam logic [5:0] REG_OE  = 6'd1;
  localparam logic [5:0] REG_IN  = 6'd2;

  logic [5:0]  reg_idx;
  logic        wr_req;
  logic [31:0] out_q;
  logic [31:0] oe_q;

  assign reg_idx = adr_i[7:2];
  assign wr_req  = stb_i && we_i;
  // Zero wait state for reads and writes
  assign ack_o   = stb_i;

  // Byte-masked register writes
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_q <= '0;
      oe_q  <= '0;
    end else begin
      for (int b = 0; b < 4; b++) begin
        if (wr_req && sel_i[b] && (reg_idx == REG_OUT)) begin
          out_q[b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
        if (wr_req && sel_i[b] && (reg_idx == REG_OE)) begin
          oe_q[b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // Readback, input register is read only
  always_comb begin
    unique case (reg_idx)
      REG_OUT: rdata_o = out_q;
      REG_OE:  rdata_o = oe_q;
      REG_IN:  rdata_o = gpio_i;
      default: rdata_o = '0;
    endcase
  end

  assign gpio_o    = out_q;
  assign gpio_oe_o = oe_q;

endmodule

// File: design/line_ram_slave.sv
// Cache-line RAM slave with strobe expansion, latency pipeline, burst buffer and word select
`timescale 1ns/1ps
`include "ceres_config.svh"

module line_ram_slave
  import ceres_bus_pkg::*;
  import ceres_mem_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        stb_i,
  input  logic        we_i,
  input  logic [31:0] adr_i,
  input  logic [31:0] wdata_i,
  input  logic [3:0]  sel_i,
  input  wb_cti_e     cti_i,
  output logic        ack_o,
  output logic [31:0] rdata_o,
  output logic        burst_active_o
);

  // ==================================================
  // Geometry
  // ==================================================
  localparam int LINE_W         = `CERES_LINE_W;
  localparam int LINE_BYTES     = LINE_W / 8;
  localparam int WORDS_PER_LINE = LINE_W / 32;
  localparam int LINES          = `CERES_RAM_WORDS / WORDS_PER_LINE;
  localparam int IDX_W          = $clog2(LINES);
  localparam int OFF_LSB        = $clog2(LINE_BYTES);
  localparam int LATENCY        = `CERES_RAM_LATENCY;

  ram_state_e            state_q;
  ram_state_e            state_d;
  logic [LATENCY-1:0]    delay_q;
  logic [LINE_W-1:0]     mem [LINES];
  // Line buffer, also the registered read port
  logic [LINE_W-1:0]     line_q;
  logic [LINE_W-1:0]     wdata_exp;
  logic [LINE_BYTES-1:0] wstrb_exp;
  logic [IDX_W-1:0]      line_idx;
  word_off_t             word_off;
  logic                  wr_req;
  logic                  rd_req;
  logic                  first_ack;
  logic                  beat_ack;
  logic                  load_line;

  // Line index above the byte offset, word within line below it
  assign line_idx  = adr_i[OFF_LSB +: IDX_W];
  assign word_off  = adr_i[3:2];
  assign wr_req    = stb_i && we_i;
  assign rd_req    = stb_i && !we_i;

  // First beat acks when the pipeline tail is set
  assign first_ack = (state_q == RAM_WAIT) && delay_q[LATENCY-1] && rd_req;
  // Buffered beats ack in the cycle they are seen
  assign beat_ack  = (state_q == RAM_BURST) && rd_req;
  // Writes never wait
  assign ack_o     = wr_req || first_ack || beat_ack;

  // Reload while waiting, so the ack edge captures the final line
  assign load_line = ((state_q == RAM_IDLE) && rd_req) || (state_q == RAM_WAIT);

  assign rdata_o        = line_q[word_off*32 +: 32];
  assign burst_active_o = (state_q == RAM_BURST);

  // ==================================================
  // Write data and strobe expansion
  // ==================================================
  always_comb begin
    wstrb_exp = '0;
    // Same word in every slot of the line
    for (int w = 0; w < WORDS_PER_LINE; w++) begin
      wdata_exp[w*32 +: 32] = wdata_i;
    end
    // Byte enables only in the addressed slot
    if (wr_req) begin
      wstrb_exp[word_off*4 +: 4] = sel_i;
    end
  end

  // Storage and line buffer
  always_ff @(posedge clk_i) begin
    if (load_line) begin
      line_q <= mem[line_idx];
    end
    for (int b = 0; b < LINE_BYTES; b++) begin
      if (wstrb_exp[b]) begin
        mem[line_idx][b*8 +: 8] <= wdata_exp[b*8 +: 8];
      end
    end
  end

  // ==================================================
  // Read controller
  // ==================================================
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      RAM_IDLE: begin
        if (rd_req) begin
          state_d = RAM_WAIT;
        end
      end
      RAM_WAIT: begin
        // Stay on the buffer only for an incrementing burst
        if (first_ack) begin
          state_d = (cti_i == CTI_INCR) ? RAM_BURST : RAM_IDLE;
        end
      end
      RAM_BURST: begin
        if (beat_ack && (cti_i == CTI_EOB)) begin
          state_d = RAM_IDLE;
        end
      end
      default: state_d = RAM_IDLE;
    endcase
  end

  // Latency shift pipeline, one token per read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= RAM_IDLE;
      delay_q <= '0;
    end else begin
      state_q <= state_d;
      if (first_ack) begin
        delay_q <= '0;
      end else begin
        delay_q <= {delay_q[LATENCY-2:0], (state_q == RAM_IDLE) && rd_req};
      end
    end
  end

endmodule

// File: design/wb_slave_router.sv
// Wishbone region decoder, strobe gating, response mux and status LED register
`timescale 1ns/1ps
`include "ceres_config.svh"

module wb_slave_router
  import ceres_bus_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        cyc_i,
  input  logic        stb_i,
  input  logic [31:0] adr_i,
  input  logic        ram_ack_i,
  input  logic [31:0] ram_rdata_i,
  input  logic        gpio_ack_i,
  input  logic [31:0] gpio_rdata_i,
  input  logic        burst_active_i,
  output logic        ram_stb_o,
  output logic        gpio_stb_o,
  output logic        ack_o,
  output logic [31:0] rdata_o,
  output logic [3:0]  status_led_o
);

  logic       req;
  slave_sel_e sel;
  slave_sel_e last_sel_q;
  logic       burst_q;

  // Live request
  assign req = cyc_i && stb_i;

  // Region decode on the top nibble
  always_comb begin
    unique case (adr_i[31:28])
      `CERES_RAM_REGION:  sel = SEL_RAM;
      `CERES_GPIO_REGION: sel = SEL_GPIO;
      default:            sel = SEL_NONE;
    endcase
  end

  assign ram_stb_o  = req && (sel == SEL_RAM);
  assign gpio_stb_o = req && (sel == SEL_GPIO);

  // Unmapped requests ack at once with zero data
  always_comb begin
    unique case (sel)
      SEL_RAM: begin
        ack_o   = ram_ack_i;
        rdata_o = ram_rdata_i;
      end
      SEL_GPIO: begin
        ack_o   = gpio_ack_i;
        rdata_o = gpio_rdata_i;
      end
      default: begin
        ack_o   = req;
        rdata_o = '0;
      end
    endcase
  end

  // ==================================================
  // Status LEDs
  // ==================================================
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_sel_q <= SEL_NONE;
      burst_q    <= 1'b0;
    end else begin
      burst_q <= burst_active_i;
      // Latch the slave of each completed access
      if (ack_o) begin
        last_sel_q <= sel;
      end
    end
  end

  assign status_led_o = {1'b0, burst_q, last_sel_q};

endmodule
